/* include/demod_cfg.svh */
`ifndef DEMOD_CFG_SVH
`define DEMOD_CFG_SVH

// datapath widths
`define DEMOD_CONS_W 16
`define DEMOD_BITS_W 6
`define DEMOD_RATE_W 8

// 16-QAM inner/outer boundary on |x|
// points at 1 and 3 times 1024/sqrt(10)
`define DEMOD_QAM16_DIV 16'd648

// 64-QAM boundaries on |x|
// multiples of 1024/sqrt(42)
`define DEMOD_QAM64_DIV_0 16'd316
`define DEMOD_QAM64_DIV_1 16'd632
`define DEMOD_QAM64_DIV_2 16'd948

`endif

/* verilog/demod_pkg.sv */
`default_nettype none

`include "demod_cfg.svh"

package demod_pkg;

    // modulation codes, same numbering as the receiver datapath
    typedef enum logic [2:0] {
        MOD_BPSK  = 3'd1,
        MOD_QPSK  = 3'd2,
        MOD_QAM16 = 3'd3,
        MOD_QAM64 = 3'd4
    } mod_e;

    typedef logic signed [`DEMOD_CONS_W-1:0] cons_t;

    // unsigned so that the most negative sample still fits
    typedef logic [`DEMOD_CONS_W-1:0] mag_t;

    typedef logic [`DEMOD_BITS_W-1:0] hard_bits_t;

    // legacy view: signal-field rate code in the low nibble
    typedef struct packed {
        logic                     ht_flag;
        logic [`DEMOD_RATE_W-6:0] unused;
        logic [3:0]               code;
    } rate_legacy_t;

    // HT view: MCS below the flag
    typedef struct packed {
        logic                     ht_flag;
        logic [`DEMOD_RATE_W-2:0] mcs;
    } rate_ht_t;

    // rate word as seen from either standard, msb picks the view
    typedef union packed {
        rate_legacy_t legacy;
        rate_ht_t     ht;
    } rate_u;

endpackage

`default_nettype wire

/* verilog/symbol_input.sv */
`timescale 1ns/100ps
`default_nettype none

module symbol_input
    import demod_pkg::*;
(
    input  wire        clock,
    input  wire        reset,
    input  wire        enable_i,
    input  wire rate_u rate_i,
    input  wire cons_t cons_i_i,
    input  wire cons_t cons_q_i,
    input  wire        strobe_i,
    output cons_t      cons_i_o,
    output cons_t      cons_q_o,
    output mag_t       mag_i_o,
    output mag_t       mag_q_o,
    output mod_e       mod_o,
    output logic       strobe_o
);

    // |x|, -32768 maps to 32768
    function automatic mag_t magnitude(input cons_t value);
        return mag_t'(value < 0 ? -value : value);
    endfunction

    // rate word to modulation, unknown codes fall back to BPSK
    function automatic mod_e decode_rate(input rate_u rate);
        mod_e result;
        result = MOD_BPSK;
        if (rate.ht.ht_flag) begin
            case (rate.ht.mcs)
                7'd0:       result = MOD_BPSK;
                7'd1, 7'd2: result = MOD_QPSK;
                7'd3, 7'd4: result = MOD_QAM16;
                7'd5, 7'd6,
                7'd7:       result = MOD_QAM64;
                default:    result = MOD_BPSK;
            endcase
        end else begin
            // 802.11a signal-field codes
            case (rate.legacy.code)
                4'd11, 4'd15: result = MOD_BPSK;
                4'd10, 4'd14: result = MOD_QPSK;
                4'd9,  4'd13: result = MOD_QAM16;
                4'd8,  4'd12: result = MOD_QAM64;
                default:      result = MOD_BPSK;
            endcase
        end
        return result;
    endfunction

    // control state
    always_ff @(posedge clock) begin
        if (reset) begin
            mod_o    <= MOD_BPSK;
            strobe_o <= 1'b0;
        end else if (enable_i) begin
            mod_o    <= decode_rate(rate_i);
            strobe_o <= strobe_i;
        end
    end

    // sample and magnitudes, taken on every enabled edge
    always_ff @(posedge clock) begin
        if (enable_i) begin
            cons_i_o <= cons_i_i;
            cons_q_o <= cons_q_i;
            mag_i_o  <= magnitude(cons_i_i);
            mag_q_o  <= magnitude(cons_q_i);
        end
    end

endmodule

`default_nettype wire

/* verilog/hard_slicer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "demod_cfg.svh"

module hard_slicer
    import demod_pkg::*;
(
    input  wire        clock,
    input  wire        reset,
    input  wire        enable_i,
    input  wire cons_t cons_i_i,
    input  wire cons_t cons_q_i,
    input  wire mag_t  mag_i_i,
    input  wire mag_t  mag_q_i,
    input  wire mod_e  mod_i,
    input  wire        strobe_i,
    output hard_bits_t bits_o,
    output logic       strobe_o
);

    logic       sign_i;
    logic       sign_q;
    hard_bits_t next_bits;
    logic       strobe_q;

    // 16-QAM axis: {inner, sign}
    function automatic logic [1:0] slice_qam16(input logic sign, input mag_t mag);
        return {mag < `DEMOD_QAM16_DIV, sign};
    endfunction

    // 64-QAM axis: {middle ring, inner half, sign}
    // both bounds of the middle ring are strict
    function automatic logic [2:0] slice_qam64(input logic sign, input mag_t mag);
        logic inner;
        logic middle;
        inner  = mag < `DEMOD_QAM64_DIV_1;
        middle = (mag > `DEMOD_QAM64_DIV_0) && (mag < `DEMOD_QAM64_DIV_2);
        return {middle, inner, sign};
    endfunction

    // positive sample decodes as one
    assign sign_i = ~cons_i_i[`DEMOD_CONS_W-1];
    assign sign_q = ~cons_q_i[`DEMOD_CONS_W-1];

    always_comb begin
        next_bits = '0;
        case (mod_i)
            MOD_BPSK: begin
                next_bits[0] = sign_i;
            end
            MOD_QPSK: begin
                next_bits[1:0] = {sign_q, sign_i};
            end
            MOD_QAM16: begin
                next_bits[3:0] = {slice_qam16(sign_q, mag_q_i), slice_qam16(sign_i, mag_i_i)};
            end
            MOD_QAM64: begin
                next_bits = {slice_qam64(sign_q, mag_q_i), slice_qam64(sign_i, mag_i_i)};
            end
            default: begin
                next_bits = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bits_o   <= '0;
            strobe_q <= 1'b0;
        end else if (enable_i) begin
            bits_o   <= next_bits;
            strobe_q <= strobe_i;
        end
    end

    // a frozen pipeline never presents a valid output
    assign strobe_o = enable_i & strobe_q;

endmodule

`default_nettype wire

/* verilog/demodulate.sv */
`timescale 1ns/100ps
`default_nettype none

module demodulate
    import demod_pkg::*;
(
    input  wire        clock,
    input  wire        reset,
    input  wire        enable_i,
    input  wire rate_u rate_i,
    input  wire cons_t cons_i_i,
    input  wire cons_t cons_q_i,
    input  wire        strobe_i,
    output hard_bits_t bits_o,
    output logic       strobe_o
);

    // between the input stage and the slicer
    cons_t cons_i_s;
    cons_t cons_q_s;
    mag_t  mag_i_s;
    mag_t  mag_q_s;
    mod_e  mod_s;
    logic  strobe_s;

    // stage 1: register sample, magnitudes and modulation
    symbol_input input0 (
        .clock    (clock),
        .reset    (reset),
        .enable_i (enable_i),
        .rate_i   (rate_i),
        .cons_i_i (cons_i_i),
        .cons_q_i (cons_q_i),
        .strobe_i (strobe_i),
        .cons_i_o (cons_i_s),
        .cons_q_o (cons_q_s),
        .mag_i_o  (mag_i_s),
        .mag_q_o  (mag_q_s),
        .mod_o    (mod_s),
        .strobe_o (strobe_s)
    );

    // stage 2: hard decisions and output strobe
    hard_slicer slicer0 (
        .clock    (clock),
        .reset    (reset),
        .enable_i (enable_i),
        .cons_i_i (cons_i_s),
        .cons_q_i (cons_q_s),
        .mag_i_i  (mag_i_s),
        .mag_q_i  (mag_q_s),
        .mod_i    (mod_s),
        .strobe_i (strobe_s),
        .bits_o   (bits_o),
        .strobe_o (strobe_o)
    );

endmodule

`default_nettype wire

/* tests/demod_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module demod_assertions
    import demod_pkg::*;
(
    input wire             clock,
    input wire             reset,
    input wire             enable_i,
    input wire rate_u      rate_i,
    input wire hard_bits_t bits_out_i,
    input wire             strobe_out_i
);

    logic bpsk_in;
    logic bpsk_s1;
    logic bpsk_s2;

    // rates defined as BPSK in either view
    assign bpsk_in = rate_i.ht.ht_flag ? (rate_i.ht.mcs == 7'd0) :
                     (rate_i.legacy.code == 4'd11 || rate_i.legacy.code == 4'd15);

    // follows the rate through both enabled stages
    always_ff @(posedge clock) begin
        if (reset) begin
            bpsk_s1 <= 1'b0;
            bpsk_s2 <= 1'b0;
        end else if (enable_i) begin
            bpsk_s1 <= bpsk_in;
            bpsk_s2 <= bpsk_s1;
        end
    end

    strobe_gated: assert property (@(posedge clock) !enable_i |-> !strobe_out_i)
        else $error("strobe_o high while enable_i is low");

    strobe_after_reset: assert property (@(posedge clock) reset |=> !strobe_out_i)
        else $error("strobe_o high in the cycle after reset");

    bpsk_upper_zero: assert property (@(posedge clock) disable iff (reset)
        bpsk_s2 |-> bits_out_i[5:1] == 5'd0)
        else $error("upper hard bits set for a BPSK point");

endmodule

bind demodulate demod_assertions asrt0 (
    .clock        (clock),
    .reset        (reset),
    .enable_i     (enable_i),
    .rate_i       (rate_i),
    .bits_out_i   (bits_o),
    .strobe_out_i (strobe_o)
);

`default_nettype wire

/* tests/demod_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module demod_tb
    import demod_pkg::*;
();

    localparam int N_PER_RATE = 40;
    localparam int N_BOUND = 19;
    localparam int N_RANDOM = 400;
    // reset, 8 legacy + 16 HT/undefined rates, two boundary sweeps, two random runs, flush
    localparam int TOTAL_CYCLES = 8 + 24 * N_PER_RATE + 2 * N_BOUND + 2 * N_RANDOM + 4;
    localparam int WATCHDOG_NS = 20 * TOTAL_CYCLES + 1000;

    logic       clock;
    logic       reset;
    logic       enable_i;
    logic       strobe_i;
    rate_u      rate_i;
    cons_t      cons_i_i;
    cons_t      cons_q_i;
    hard_bits_t bits_o;
    logic       strobe_o;

    logic [31:0] lcg_state;
    int          errors;
    // {strobe, bits} with entry 0 in the output register
    logic [6:0]  model_q[$];
    int          bound_vals[N_BOUND];
    int          ht_codes[12];
    int          undef_codes[4];

    demodulate dut0 (
        .clock    (clock),
        .reset    (reset),
        .enable_i (enable_i),
        .rate_i   (rate_i),
        .cons_i_i (cons_i_i),
        .cons_q_i (cons_q_i),
        .strobe_i (strobe_i),
        .bits_o   (bits_o),
        .strobe_o (strobe_o)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // half near the decision boundaries and a few at the most negative value
    function automatic cons_t random_sample();
        logic [31:0] r;
        cons_t result;
        r = next_random();
        if (r[29:25] == 5'd0)
            result = 16'h8000;
        else if (r[31])
            result = 16'(int'(r[23:8]) % 2401 - 1200);
        else
            result = r[23:8];
        return result;
    endfunction

    // legacy codes 8..15 carry the modulation in the two low bits
    function automatic int bits_per_point(input rate_u rate);
        int nbits;
        int mcs;
        nbits = 1;
        if (rate.ht.ht_flag) begin
            mcs = int'(rate.ht.mcs);
            if (mcs >= 5 && mcs <= 7)
                nbits = 6;
            else if (mcs >= 3 && mcs <= 4)
                nbits = 4;
            else if (mcs >= 1 && mcs <= 2)
                nbits = 2;
        end else if (rate.legacy.code[3]) begin
            case (rate.legacy.code[1:0])
                2'd0: nbits = 6;
                2'd1: nbits = 4;
                2'd2: nbits = 2;
                2'd3: nbits = 1;
            endcase
        end
        return nbits;
    endfunction

    // {middle ring, inner, sign} for one axis
    function automatic logic [2:0] axis_bits(input int value, input int nbits);
        int mag;
        logic [2:0] b;
        mag = (value < 0) ? -value : value;
        b[0] = (value >= 0);
        b[1] = (nbits == 4) ? (mag < 648) : (mag < 632);
        b[2] = (mag > 316) && (mag < 948);
        return b;
    endfunction

    function automatic hard_bits_t expected_bits(input rate_u rate, input cons_t ci,
                                                 input cons_t cq);
        int nbits;
        logic [2:0] bi;
        logic [2:0] bq;
        hard_bits_t result;
        nbits = bits_per_point(rate);
        bi = axis_bits(int'(ci), nbits);
        bq = axis_bits(int'(cq), nbits);
        case (nbits)
            1:       result = {5'b0, bi[0]};
            2:       result = {4'b0, bq[0], bi[0]};
            4:       result = {2'b0, bq[1:0], bi[1:0]};
            default: result = {bq, bi};
        endcase
        return result;
    endfunction

    function automatic rate_u legacy_rate(input logic [3:0] code);
        rate_u r;
        logic [31:0] x;
        x = next_random();
        r.legacy.ht_flag = 1'b0;
        r.legacy.unused = x[18:16];
        r.legacy.code = code;
        return r;
    endfunction

    function automatic rate_u ht_rate(input logic [6:0] mcs);
        rate_u r;
        r.ht.ht_flag = 1'b1;
        r.ht.mcs = mcs;
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("mismatch %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_outputs();
        logic [6:0] head;
        head = model_q[0];
        compare("strobe_o", 32'(strobe_o), 32'(enable_i & head[6]));
        if (head[6])
            compare("bits_o", 32'(bits_o), 32'(head[5:0]));
    endtask

    // called on a falling edge and returns on the next one after checking
    task automatic apply(input logic en, input rate_u rate, input cons_t ci, input cons_t cq,
                         input logic stb);
        enable_i = en;
        rate_i   = rate;
        cons_i_i = ci;
        cons_q_i = cq;
        strobe_i = stb;
        @(posedge clock);
        if (en) begin
            model_q.push_back({stb, expected_bits(rate, ci, cq)});
            void'(model_q.pop_front());
        end
        @(negedge clock);
        check_outputs();
    endtask

    task automatic run_random(input logic random_strobe);
        logic [31:0] x;
        rate_u rate;
        logic en;
        logic stb;
        repeat (N_RANDOM) begin
            x = next_random();
            rate = x[15:8];
            en = (int'(x[31:16]) % 10) >= 3;
            stb = random_strobe ? x[7] : 1'b1;
            apply(en, rate, random_sample(), random_sample(), stb);
        end
    endtask

    initial begin
        int code;
        int k;
        lcg_state = 32'd66229;
        errors = 0;
        reset = 1'b1;
        // reset must clear the outputs even with the pipeline enabled and strobed
        enable_i = 1'b1;
        strobe_i = 1'b1;
        rate_i = '0;
        cons_i_i = '0;
        cons_q_i = '0;
        bound_vals = '{316, -316, 315, -315, 632, -632, 631, -631, 648, -648,
                       647, -647, 948, -948, 947, -947, 0, -1, -32768};
        ht_codes = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 64, 127};
        undef_codes = '{0, 3, 5, 7};

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        model_q.delete();
        model_q.push_back(7'd0);
        model_q.push_back(7'd0);

        // state right after reset
        compare("strobe_o", 32'(strobe_o), 32'h0);
        compare("bits_o", 32'(bits_o), 32'h0);

        // all eight legacy codes
        for (code = 8; code < 16; code++) begin
            repeat (N_PER_RATE)
                apply(1'b1, legacy_rate(4'(code)), random_sample(), random_sample(), 1'b1);
        end

        // HT MCS 0..7 and undefined words, which fall back to BPSK
        for (k = 0; k < 12; k++) begin
            repeat (N_PER_RATE)
                apply(1'b1, ht_rate(7'(ht_codes[k])), random_sample(), random_sample(), 1'b1);
        end
        for (k = 0; k < 4; k++) begin
            repeat (N_PER_RATE)
                apply(1'b1, legacy_rate(4'(undef_codes[k])), random_sample(), random_sample(),
                      1'b1);
        end

        // exact boundaries under 16-QAM then 64-QAM
        for (k = 0; k < N_BOUND; k++)
            apply(1'b1, legacy_rate(4'd9), 16'(bound_vals[k]),
                  16'(bound_vals[(k + 5) % N_BOUND]), 1'b1);
        for (k = 0; k < N_BOUND; k++)
            apply(1'b1, legacy_rate(4'd8), 16'(bound_vals[k]),
                  16'(bound_vals[(k + 11) % N_BOUND]), 1'b1);

        // random enable and then random enable and strobe
        run_random(1'b0);
        run_random(1'b1);

        // drain the pipeline
        repeat (4) apply(1'b1, ht_rate(7'd0), 16'sd0, 16'sd0, 1'b0);

        $display("run complete, %0d errors", errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: stimulus did not complete within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
verilog/demod_pkg.sv
verilog/symbol_input.sv
verilog/hard_slicer.sv
verilog/demodulate.sv
tests/demod_assertions.sv
tests/demod_tb.sv

/* Makefile */
SOURCES := $(shell grep -v '^+' src.f)

.PHONY: all run clean

all: obj_dir/Vdemod_tb

obj_dir/Vdemod_tb: src.f $(SOURCES) include/demod_cfg.svh
	verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
		--top-module demod_tb -f src.f

run: obj_dir/Vdemod_tb
	obj_dir/Vdemod_tb | tee sim.log
	grep -q '^TEST OK$$' sim.log

clean:
	rm -rf obj_dir sim.log
